/* logic/bru_pkg.sv */
`default_nettype none

package bru_pkg;

	// ############################
	// Widths
	// ############################

	localparam int XLEN = 64;
	localparam int NREG = 32; // Architectural integer registers, x0 included
	localparam int REG_IDX_W = $clog2(NREG);

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [63:0] pc_t;
	typedef logic [63:0] imm_t; // Already sign extended by decode

	// ############################
	// Branch operations
	// ############################

	// Encoded as the funct3 field of the RV64 branch instructions
	typedef enum logic [2:0] {
		bru_beq  = 3'b000,
		bru_bne  = 3'b001,
		bru_blt  = 3'b100,
		bru_bge  = 3'b101,
		bru_bltu = 3'b110,
		bru_bgeu = 3'b111
	} bru_op_e;

	// ############################
	// Stage words
	// ############################

	// One entry of the issue queue, still carrying register indices
	typedef struct packed {
		bru_op_e  op;
		reg_idx_t rs1;
		reg_idx_t rs2;
		pc_t      pc;
		imm_t     imm;
	} bru_issue_info_t;

	// Issue to execute, with operands already read from the register file
	typedef struct packed {
		bru_op_e op;
		xlen_t   op1;
		xlen_t   op2;
		pc_t     pc;
		imm_t    imm;
	} bru_exeparam_t;

	// Resolved branch
	typedef struct packed {
		logic taken;
		pc_t  next_pc;
	} bru_res_t;

	// One register write-back from any execution unit
	typedef struct packed {
		reg_idx_t idx;
		xlen_t    data;
	} reg_wb_t;

endpackage

`default_nettype wire

/* logic/bru_issue_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module bru_issue_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                     CLK,
	input  logic                     rst_n,

	input  logic                     push_valid,
	input  bru_pkg::bru_issue_info_t push_info,
	output logic                     push_ready,

	input  logic                     bru_fifo_pop,
	output logic                     bru_fifo_empty,
	output bru_pkg::bru_issue_info_t bru_issue_info
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	bru_pkg::bru_issue_info_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count; // One bit wider so that a full queue can be told apart
	logic             do_push;
	logic             do_pop;

	assign push_ready     = (count != FIFO_DEPTH[PTR_W:0]);
	assign bru_fifo_empty = (count == '0);
	assign bru_issue_info = mem[rd_ptr]; // Head entry is visible without a read strobe

	assign do_push = push_valid && push_ready;
	assign do_pop  = bru_fifo_pop && !bru_fifo_empty;

	// ############################
	// Pointers and occupancy
	// ############################

	// The depth is a power of two, so the pointers simply wrap around
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// A push and a pop in the same cycle leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Storage
	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= push_info;
		end
	end

endmodule

`default_nettype wire

/* logic/reg_file_wblog.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file_wblog (
	input  logic               CLK,
	input  logic               rst_n,

	// A producer has been dispatched for this register
	input  logic               rsv_valid,
	input  bru_pkg::reg_idx_t  rsv_idx,

	// A producer has finished
	input  logic               wb_valid,
	input  bru_pkg::reg_wb_t   wb,

	// Read ports
	input  bru_pkg::reg_idx_t  rs1,
	input  bru_pkg::reg_idx_t  rs2,
	output bru_pkg::xlen_t     src1,
	output bru_pkg::xlen_t     src2,
	output logic               rs1_ready,
	output logic               rs2_ready
);

	bru_pkg::xlen_t           regs [bru_pkg::NREG];
	logic [bru_pkg::NREG-1:0] wb_log; // Set means the register holds its final value

	logic wb_en;
	logic rsv_en;

	// x0 is never written and never reserved
	assign wb_en  = wb_valid && (wb.idx != '0);
	assign rsv_en = rsv_valid && (rsv_idx != '0);

	// ############################
	// Write-back log
	// ############################

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_log <= '1;
		end else begin
			if (wb_en) begin
				wb_log[wb.idx] <= 1'b1;
			end
			// Written last so the newer producer keeps the register pending
			if (rsv_en) begin
				wb_log[rsv_idx] <= 1'b0;
			end
		end
	end

	// Data storage
	always_ff @(posedge CLK) begin
		if (wb_en) begin
			regs[wb.idx] <= wb.data;
		end
	end

	// ############################
	// Read ports
	// ############################

	// New write-back data shows up a cycle later as there is no bypass
	assign src1 = (rs1 == '0) ? '0 : regs[rs1];
	assign src2 = (rs2 == '0) ? '0 : regs[rs2];

	assign rs1_ready = wb_log[rs1];
	assign rs2_ready = wb_log[rs2];

endmodule

`default_nettype wire

/* logic/bru_issue.sv */
`timescale 1ns/1ns
`default_nettype none

module bru_issue (
	input  logic                     CLK,
	input  logic                     rst_n,

	// Issue queue side
	output logic                     bru_fifo_pop,
	input  logic                     bru_fifo_empty,
	input  bru_pkg::bru_issue_info_t bru_issue_info,

	// Register file side
	output bru_pkg::reg_idx_t        rs1,
	output bru_pkg::reg_idx_t        rs2,
	input  bru_pkg::xlen_t           src1,
	input  bru_pkg::xlen_t           src2,
	input  logic                     rs1_ready,
	input  logic                     rs2_ready,

	// Execute side
	input  logic                     bru_exeparam_ready,
	output logic                     bru_exeparam_valid,
	output bru_pkg::bru_exeparam_t   bru_exeparam
);

	bru_pkg::bru_exeparam_t bru_exeparam_dnxt;
	logic                   bru_is_clear_raw;

	// ############################
	// Hazard check
	// ############################

	assign rs1 = bru_issue_info.rs1;
	assign rs2 = bru_issue_info.rs2;

	// Both producers must have written back before the head may leave
	assign bru_is_clear_raw = !bru_fifo_empty && rs1_ready && rs2_ready;

	// The head only leaves when execute can take it in the same edge
	assign bru_fifo_pop = bru_exeparam_ready && bru_is_clear_raw;

	// ############################
	// Parameter word
	// ############################

	always_comb begin
		bru_exeparam_dnxt.op  = bru_issue_info.op;
		bru_exeparam_dnxt.op1 = src1;
		bru_exeparam_dnxt.op2 = src2;
		bru_exeparam_dnxt.pc  = bru_issue_info.pc;
		bru_exeparam_dnxt.imm = bru_issue_info.imm;
	end

	// Valid drops back to zero when execute takes a word and nothing new is clear
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			bru_exeparam_valid <= 1'b0;
		end else if (bru_exeparam_ready) begin
			bru_exeparam_valid <= bru_is_clear_raw;
		end
	end

	always_ff @(posedge CLK) begin
		if (bru_exeparam_ready) begin
			bru_exeparam <= bru_exeparam_dnxt; // Held while execute stalls
		end
	end

endmodule

`default_nettype wire

/* logic/bru_exe.sv */
`timescale 1ns/1ns
`default_nettype none

module bru_exe (
	input  logic                   CLK,
	input  logic                   rst_n,

	input  logic                   bru_exeparam_valid,
	input  bru_pkg::bru_exeparam_t bru_exeparam,
	output logic                   bru_exeparam_ready,

	output logic                   res_valid,
	output bru_pkg::bru_res_t      res,
	input  logic                   res_ready
);

	bru_pkg::xlen_t    op1;
	bru_pkg::xlen_t    op2;
	logic              taken;
	bru_pkg::bru_res_t res_dnxt;

	assign op1 = bru_exeparam.op1;
	assign op2 = bru_exeparam.op2;

	// The result register is free when empty or when its word leaves this cycle
	assign bru_exeparam_ready = !res_valid || res_ready;

	// ############################
	// Direction and target
	// ############################

	always_comb begin
		unique case (bru_exeparam.op)
			bru_pkg::bru_beq:  taken = (op1 == op2);
			bru_pkg::bru_bne:  taken = (op1 != op2);
			bru_pkg::bru_blt:  taken = ($signed(op1) < $signed(op2));
			bru_pkg::bru_bge:  taken = ($signed(op1) >= $signed(op2));
			bru_pkg::bru_bltu: taken = (op1 < op2);
			bru_pkg::bru_bgeu: taken = (op1 >= op2);
			default:           taken = 1'b0; // Unused encodings fall through
		endcase
	end

	always_comb begin
		res_dnxt.taken   = taken;
		res_dnxt.next_pc = taken ? (bru_exeparam.pc + bru_exeparam.imm)
		                         : (bru_exeparam.pc + 64'd4);
	end

	// ############################
	// Result register
	// ############################

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else if (bru_exeparam_ready) begin
			res_valid <= bru_exeparam_valid;
		end
	end

	// Only a valid word is captured so an idle cycle keeps the last result
	always_ff @(posedge CLK) begin
		if (bru_exeparam_ready && bru_exeparam_valid) begin
			res <= res_dnxt;
		end
	end

endmodule

`default_nettype wire

/* logic/bru_top.sv */
`timescale 1ns/1ns
`default_nettype none

module bru_top #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                     CLK,
	input  logic                     rst_n,

	// Dispatch
	input  logic                     disp_valid,
	input  bru_pkg::bru_issue_info_t disp_info,
	output logic                     disp_ready,

	// Register tracking from the rest of the core
	input  logic                     rsv_valid,
	input  bru_pkg::reg_idx_t        rsv_idx,
	input  logic                     wb_valid,
	input  bru_pkg::reg_wb_t         wb,

	// Resolved branches
	output logic                     res_valid,
	output bru_pkg::bru_res_t        res,
	input  logic                     res_ready
);

	logic                     bru_fifo_pop;
	logic                     bru_fifo_empty;
	bru_pkg::bru_issue_info_t bru_issue_info;

	bru_pkg::reg_idx_t        rs1;
	bru_pkg::reg_idx_t        rs2;
	bru_pkg::xlen_t           src1;
	bru_pkg::xlen_t           src2;
	logic                     rs1_ready;
	logic                     rs2_ready;

	logic                     bru_exeparam_ready;
	logic                     bru_exeparam_valid;
	bru_pkg::bru_exeparam_t   bru_exeparam;

	// ############################
	// Pipeline
	// ############################

	bru_issue_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.push_valid     (disp_valid),
		.push_info      (disp_info),
		.push_ready     (disp_ready),
		.bru_fifo_pop   (bru_fifo_pop),
		.bru_fifo_empty (bru_fifo_empty),
		.bru_issue_info (bru_issue_info)
	);

	reg_file_wblog u_regfile (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.rsv_valid (rsv_valid),
		.rsv_idx   (rsv_idx),
		.wb_valid  (wb_valid),
		.wb        (wb),
		.rs1       (rs1),
		.rs2       (rs2),
		.src1      (src1),
		.src2      (src2),
		.rs1_ready (rs1_ready),
		.rs2_ready (rs2_ready)
	);

	bru_issue u_issue (
		.CLK                (CLK),
		.rst_n              (rst_n),
		.bru_fifo_pop       (bru_fifo_pop),
		.bru_fifo_empty     (bru_fifo_empty),
		.bru_issue_info     (bru_issue_info),
		.rs1                (rs1),
		.rs2                (rs2),
		.src1               (src1),
		.src2               (src2),
		.rs1_ready          (rs1_ready),
		.rs2_ready          (rs2_ready),
		.bru_exeparam_ready (bru_exeparam_ready),
		.bru_exeparam_valid (bru_exeparam_valid),
		.bru_exeparam       (bru_exeparam)
	);

	bru_exe u_exe (
		.CLK                (CLK),
		.rst_n              (rst_n),
		.bru_exeparam_valid (bru_exeparam_valid),
		.bru_exeparam       (bru_exeparam),
		.bru_exeparam_ready (bru_exeparam_ready),
		.res_valid          (res_valid),
		.res                (res),
		.res_ready          (res_ready)
	);

endmodule

`default_nettype wire

/* bench/bru_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module bru_assert (
	input logic              CLK,
	input logic              rst_n,
	input logic              disp_ready,
	input logic              res_valid,
	input logic              res_ready,
	input bru_pkg::bru_res_t res,
	input logic              bru_fifo_pop,
	input logic              bru_fifo_empty
);

	// A stalled result stays put until the consumer takes it
	property res_held_p;
		@(posedge CLK) disable iff (!rst_n)
			res_valid && !res_ready |=> res_valid && $stable(res);
	endproperty

	property no_pop_when_empty_p;
		@(posedge CLK) disable iff (!rst_n)
			bru_fifo_empty |-> !bru_fifo_pop;
	endproperty

	property reset_state_p;
		@(posedge CLK) $rose(rst_n) |=> disp_ready && !res_valid;
	endproperty

	assert property (res_held_p) else $error("res changed while waiting for res_ready");
	assert property (no_pop_when_empty_p) else $error("issue queue popped while empty");
	assert property (reset_state_p) else $error("wrong handshake state after reset");

endmodule

bind bru_top bru_assert u_assert (
	.CLK            (CLK),
	.rst_n          (rst_n),
	.disp_ready     (disp_ready),
	.res_valid      (res_valid),
	.res_ready      (res_ready),
	.res            (res),
	.bru_fifo_pop   (bru_fifo_pop),
	.bru_fifo_empty (bru_fifo_empty)
);

`default_nettype wire

/* bench/bru_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module bru_tb;

	localparam int FIFO_DEPTH   = 4;
	localparam int CLK_PERIOD   = 20;
	localparam int N_RAND       = 4;  // Random branches per opcode
	localparam int WAIT_CYCLES  = 10;
	localparam int DRAIN_CYCLES = 40;

	// Cycle budget of each test, summed up for the watchdog
	localparam int T_RESET  = 8;
	localparam int T_OPCODE = 2 * 18 + 2 * 6 * (N_RAND + 3) + DRAIN_CYCLES;
	localparam int T_WAIT   = 8 + WAIT_CYCLES + DRAIN_CYCLES;
	localparam int T_BACKP  = 2 * (FIFO_DEPTH + 2) + 6 + DRAIN_CYCLES;
	localparam int T_X0     = 2 * 9 + DRAIN_CYCLES;
	localparam int WATCHDOG_CYCLES = T_RESET + T_OPCODE + T_WAIT + T_BACKP + T_X0 + 100;

	logic                     CLK;
	logic                     rst_n;
	logic                     disp_valid;
	bru_pkg::bru_issue_info_t disp_info;
	logic                     disp_ready;
	logic                     rsv_valid;
	bru_pkg::reg_idx_t        rsv_idx;
	logic                     wb_valid;
	bru_pkg::reg_wb_t         wb;
	logic                     res_valid;
	bru_pkg::bru_res_t        res;
	logic                     res_ready;

	bru_pkg::xlen_t    model_regs [bru_pkg::NREG]; // Mirror of every write-back
	bru_pkg::bru_res_t exp_q [$];                  // Expected results in dispatch order
	integer            seed = 5110;
	int                n_tests;
	int                n_checks;
	int                n_errors;
	int                test_err0;

	bru_top #(.FIFO_DEPTH(FIFO_DEPTH)) uut (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.disp_valid (disp_valid),
		.disp_info  (disp_info),
		.disp_ready (disp_ready),
		.rsv_valid  (rsv_valid),
		.rsv_idx    (rsv_idx),
		.wb_valid   (wb_valid),
		.wb         (wb),
		.res_valid  (res_valid),
		.res        (res),
		.res_ready  (res_ready)
	);

	initial CLK = 1'b0;
	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// ############################
	// Reference model
	// ############################

	function automatic bru_pkg::bru_res_t branch_model(input bru_pkg::bru_op_e op,
			input bru_pkg::xlen_t a, input bru_pkg::xlen_t b,
			input bru_pkg::pc_t pc, input bru_pkg::imm_t imm);
		bru_pkg::bru_res_t r;
		logic [63:0]       sa;
		logic [63:0]       sb;
		logic              t;
		sa = a ^ {1'b1, 63'd0}; // Flipping the sign bit turns a signed compare unsigned
		sb = b ^ {1'b1, 63'd0};
		case (op)
			bru_pkg::bru_beq:  t = (a == b);
			bru_pkg::bru_bne:  t = !(a == b);
			bru_pkg::bru_blt:  t = (sa < sb);
			bru_pkg::bru_bge:  t = !(sa < sb);
			bru_pkg::bru_bltu: t = (a < b);
			bru_pkg::bru_bgeu: t = !(a < b);
			default:           t = 1'b0;
		endcase
		r.taken   = t;
		r.next_pc = t ? pc + imm : pc + 64'd4;
		return r;
	endfunction

	function automatic bru_pkg::bru_op_e op_at(input int k);
		case (k)
			0:       return bru_pkg::bru_beq;
			1:       return bru_pkg::bru_bne;
			2:       return bru_pkg::bru_blt;
			3:       return bru_pkg::bru_bge;
			4:       return bru_pkg::bru_bltu;
			default: return bru_pkg::bru_bgeu;
		endcase
	endfunction

	function automatic bru_pkg::reg_idx_t rand_reg();
		return bru_pkg::reg_idx_t'(1 + ({$random(seed)} % 15)); // Only x1 to x15 are loaded
	endfunction

	function automatic bru_pkg::pc_t rand_pc();
		bru_pkg::pc_t p;
		p = {$random(seed), $random(seed)};
		p[1:0] = 2'b00;
		return p;
	endfunction

	function automatic bru_pkg::imm_t rand_imm();
		logic [31:0] r;
		r = $random(seed);
		return {{51{r[12]}}, r[12:1], 1'b0}; // B-type range and always even
	endfunction

	// ############################
	// Checks
	// ############################

	task automatic check_res(input string name, input bru_pkg::bru_res_t got,
			input bru_pkg::bru_res_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED %s: expected %h got %h", name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAILED %s: expected %h got %h", name, exp, got);
		end
	endtask

	// Sampled at the falling edge where res is stable before the transfer edge
	always @(negedge CLK) begin
		if (rst_n && res_valid && res_ready) begin
			if (exp_q.size() == 0) begin
				n_errors++;
				$display("A result %h came out with no branch outstanding", res);
			end else begin
				check_res("res", res, exp_q.pop_front());
			end
		end
	end

	task automatic finish_test(input string name);
		n_tests++;
		if (n_errors == test_err0) begin
			$display("test %s done, no errors", name);
		end else begin
			$display("test %s done, %0d errors", name, n_errors - test_err0);
		end
	endtask

	// ############################
	// Drivers
	// ############################

	task automatic write_reg(input bru_pkg::reg_idx_t idx, input bru_pkg::xlen_t data);
		wb_valid = 1'b1;
		wb.idx   = idx;
		wb.data  = data;
		@(posedge CLK);
		#1;
		wb_valid = 1'b0;
		if (idx != '0) begin
			model_regs[idx] = data; // x0 ignores writes
		end
	endtask

	task automatic reserve_reg(input bru_pkg::reg_idx_t idx);
		rsv_valid = 1'b1;
		rsv_idx   = idx;
		@(posedge CLK);
		#1;
		rsv_valid = 1'b0;
	endtask

	task automatic dispatch_raw(input bru_pkg::bru_op_e op, input bru_pkg::reg_idx_t rs1,
			input bru_pkg::reg_idx_t rs2, input bru_pkg::pc_t pc, input bru_pkg::imm_t imm);
		logic accepted;
		disp_info.op  = op;
		disp_info.rs1 = rs1;
		disp_info.rs2 = rs2;
		disp_info.pc  = pc;
		disp_info.imm = imm;
		disp_valid    = 1'b1;
		accepted      = 1'b0;
		while (!accepted) begin
			@(negedge CLK);
			accepted = disp_ready;
			@(posedge CLK);
			#1;
		end
		disp_valid = 1'b0;
	endtask

	task automatic dispatch(input bru_pkg::bru_op_e op, input bru_pkg::reg_idx_t rs1,
			input bru_pkg::reg_idx_t rs2, input bru_pkg::pc_t pc, input bru_pkg::imm_t imm);
		dispatch_raw(op, rs1, rs2, pc, imm);
		exp_q.push_back(branch_model(op, model_regs[rs1], model_regs[rs2], pc, imm));
	endtask

	// Waits until every dispatched branch has resolved
	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_CYCLES) begin
			@(posedge CLK);
			#1;
			n++;
		end
		if (exp_q.size() != 0) begin
			n_errors++;
			$display("%0d branches gave no result within %0d cycles", exp_q.size(), n);
			exp_q.delete();
		end
	endtask

	// ############################
	// Tests
	// ############################

	task automatic test_reset_state();
		test_err0 = n_errors;
		@(negedge CLK);
		check_bit("res_valid", res_valid, 1'b0);
		check_bit("disp_ready", disp_ready, 1'b1);
		@(posedge CLK);
		#1;
		finish_test("reset_state");
	endtask

	task automatic test_every_opcode();
		bru_pkg::bru_op_e op;
		test_err0 = n_errors;
		for (int i = 1; i < 16; i++) begin
			write_reg(bru_pkg::reg_idx_t'(i), {$random(seed), $random(seed)});
		end
		write_reg(5'd3, model_regs[2]);                    // x3 equals x2
		write_reg(5'd4, {32'hffff_fff0, $random(seed)}); // Negative
		write_reg(5'd5, {32'h0000_0010, $random(seed)}); // Positive
		for (int k = 0; k < 6; k++) begin
			op = op_at(k);
			dispatch(op, 5'd2, 5'd3, rand_pc(), rand_imm());
			dispatch(op, 5'd4, 5'd5, rand_pc(), rand_imm());
			dispatch(op, 5'd5, 5'd4, rand_pc(), rand_imm());
			for (int j = 0; j < N_RAND; j++) begin
				dispatch(op, rand_reg(), rand_reg(), rand_pc(), rand_imm());
			end
		end
		drain();
		finish_test("every_opcode");
	endtask

	task automatic test_operand_wait();
		bru_pkg::pc_t  pc;
		bru_pkg::imm_t imm;
		test_err0 = n_errors;
		pc  = rand_pc();
		imm = rand_imm();
		write_reg(5'd6, 64'hffff_ffff_ffff_fffb); // -5
		write_reg(5'd7, 64'd100);                 // Stale value that would make bge fall through
		reserve_reg(5'd7);
		dispatch_raw(bru_pkg::bru_bge, 5'd6, 5'd7, pc, imm);
		repeat (WAIT_CYCLES) begin
			@(negedge CLK);
			check_bit("res_valid", res_valid, 1'b0);
			@(posedge CLK);
			#1;
		end
		write_reg(5'd7, 64'hffff_ffff_ffff_fff7); // -9 makes the branch taken
		exp_q.push_back(branch_model(bru_pkg::bru_bge, model_regs[6], model_regs[7], pc, imm));
		drain();
		finish_test("operand_wait");
	endtask

	task automatic test_back_pressure();
		test_err0 = n_errors;
		res_ready = 1'b0;
		for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
			dispatch(op_at(i % 6), rand_reg(), rand_reg(), rand_pc(), rand_imm());
		end
		disp_valid = 1'b1; // One more offer that the full queue must refuse
		repeat (3) begin
			@(negedge CLK);
			check_bit("disp_ready", disp_ready, 1'b0);
			@(posedge CLK);
			#1;
		end
		disp_valid = 1'b0;
		res_ready  = 1'b1;
		drain();
		finish_test("back_pressure");
	endtask

	task automatic test_x0();
		test_err0 = n_errors;
		write_reg(5'd0, 64'hdead_beef_0000_0001);
		write_reg(5'd8, 64'hffff_ffff_ffff_fff0);
		write_reg(5'd9, 64'd77);
		dispatch(bru_pkg::bru_beq, 5'd0, 5'd0, rand_pc(), rand_imm());
		dispatch(bru_pkg::bru_bne, 5'd0, 5'd0, rand_pc(), rand_imm());
		dispatch(bru_pkg::bru_bltu, 5'd0, 5'd9, rand_pc(), rand_imm());
		dispatch(bru_pkg::bru_bge, 5'd0, 5'd8, rand_pc(), rand_imm());
		dispatch(bru_pkg::bru_blt, 5'd8, 5'd0, rand_pc(), rand_imm());
		dispatch(bru_pkg::bru_bgeu, 5'd0, 5'd9, rand_pc(), rand_imm());
		drain();
		finish_test("x0");
	endtask

	// ############################
	// Sequence
	// ############################

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		for (int i = 0; i < bru_pkg::NREG; i++) begin
			model_regs[i] = '0;
		end
		n_tests    = 0;
		n_checks   = 0;
		n_errors   = 0;
		test_err0  = 0;
		rst_n      = 1'b0;
		disp_valid = 1'b0;
		disp_info  = '0;
		rsv_valid  = 1'b0;
		rsv_idx    = '0;
		wb_valid   = 1'b0;
		wb         = '0;
		res_ready  = 1'b1;
		repeat (5) @(posedge CLK);
		#1;
		rst_n = 1'b1;

		test_reset_state();
		test_every_opcode();
		test_operand_wait();
		test_back_pressure();
		test_x0();

		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bru.f */
logic/bru_pkg.sv
logic/bru_issue_fifo.sv
logic/reg_file_wblog.sv
logic/bru_issue.sv
logic/bru_exe.sv
logic/bru_top.sv
bench/bru_assert.sv
bench/bru_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = bru_tb
FILELIST  = bru.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
